/* Bender.yml */
package:
  name: warp_core

sources:
  - rtl/warp_pkg.sv
  - rtl/warp_decode.sv
  - rtl/warp_issue_queue.sv
  - rtl/warp_xrf.sv
  - rtl/warp_execute.sv
  - rtl/warp_core.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/warp_core_properties.sv
      - verification/tb_warp_core.sv

/* files.f */
rtl/warp_pkg.sv
rtl/warp_decode.sv
rtl/warp_issue_queue.sv
rtl/warp_xrf.sv
rtl/warp_execute.sv
rtl/warp_core.sv
verification/tb_clock.sv
verification/warp_core_properties.sv
verification/tb_warp_core.sv

/* rtl/warp_core.sv */
`timescale 1ns/1ps

module warp_core (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_inst_valid,
    input  logic [warp_pkg::ILEN-1:0]       i_inst,
    output logic                            o_inst_ready,
    output logic                            o_wb_valid,
    output logic [warp_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [warp_pkg::XLEN-1:0]       o_wb_data,
    input  logic                            i_wb_ready
);
    logic                            dec_valid;
    logic                            dec_ready;
    logic [warp_pkg::ILEN-1:0]       dec_inst;
    logic                            iq_valid;
    logic                            iq_ready;
    logic [warp_pkg::ILEN-1:0]       iq_inst;
    logic [warp_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [warp_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [warp_pkg::XLEN-1:0]       rs1_rdata;
    logic [warp_pkg::XLEN-1:0]       rs2_rdata;
    logic                            rd_wen;
    logic [warp_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [warp_pkg::XLEN-1:0]       rd_wdata;

    warp_decode decode (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
        .o_out_valid(dec_valid), .o_out_inst(dec_inst), .i_out_ready(dec_ready)
    );

    warp_issue_queue #(
        .DEPTH(warp_pkg::QUEUE_DEPTH)
    ) issue_queue (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_in_valid(dec_valid), .i_in_inst(dec_inst), .o_in_ready(dec_ready),
        .o_out_valid(iq_valid), .o_out_inst(iq_inst), .i_out_ready(iq_ready)
    );

    // execute reads operands combinationally and writes back on its own edge
    warp_execute execute (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_valid(iq_valid), .i_inst(iq_inst), .o_ready(iq_ready),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata),
        .o_rd_wen(rd_wen), .o_rd_addr(rd_addr), .o_rd_wdata(rd_wdata),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .i_wb_ready(i_wb_ready)
    );

    warp_xrf xrf (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata),
        .i_rd_wen(rd_wen), .i_rd_addr(rd_addr), .i_rd_wdata(rd_wdata)
    );
endmodule

/* rtl/warp_decode.sv */
`timescale 1ns/1ps

module warp_decode (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_inst_valid,
    input  logic [warp_pkg::ILEN-1:0] i_inst,
    output logic                      o_inst_ready,
    output logic                      o_out_valid,
    output logic [warp_pkg::ILEN-1:0] o_out_inst,
    input  logic                      i_out_ready
);
    warp_pkg::inst_u           inst;
    logic                      f3_alu;
    logic                      funct_ok;
    logic                      legal;
    logic                      out_valid;
    logic [warp_pkg::ILEN-1:0] out_inst;

    assign inst = i_inst;

    // funct3 values shared by the register and immediate forms, shifts excluded
    always_comb begin
        case (inst.r.funct3)
            warp_pkg::F3_ADD_SUB,
            warp_pkg::F3_SLT,
            warp_pkg::F3_SLTU,
            warp_pkg::F3_XOR,
            warp_pkg::F3_OR,
            warp_pkg::F3_AND: f3_alu = 1'b1;
            default:          f3_alu = 1'b0;
        endcase
    end

    always_comb begin
        case (inst.r.opcode)
            warp_pkg::OP_REG: begin
                funct_ok = f3_alu && ((inst.r.funct7 == warp_pkg::F7_BASE) ||
                           ((inst.r.funct7 == warp_pkg::F7_SUB) &&
                            (inst.r.funct3 == warp_pkg::F3_ADD_SUB)));
            end
            warp_pkg::OP_IMM: begin
                funct_ok = f3_alu;
            end
            warp_pkg::OP_REG_W: begin
                funct_ok = (inst.r.funct3 == warp_pkg::F3_ADD_SUB) &&
                           ((inst.r.funct7 == warp_pkg::F7_BASE) ||
                            (inst.r.funct7 == warp_pkg::F7_SUB));
            end
            warp_pkg::OP_IMM_W: begin
                funct_ok = (inst.i.funct3 == warp_pkg::F3_ADD_SUB);
            end
            default: begin
                funct_ok = 1'b0;
            end
        endcase
    end

    // writes to x0 have no visible effect, so they are dropped here as well
    assign legal = funct_ok && (inst.r.rd != '0);

    assign o_inst_ready = !out_valid || i_out_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_valid <= 1'b0;
        end else if (o_inst_ready) begin
            out_valid <= i_inst_valid && legal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_inst_ready && i_inst_valid && legal) begin
            out_inst <= i_inst;
        end
    end

    assign o_out_valid = out_valid;
    assign o_out_inst  = out_inst;
endmodule

/* rtl/warp_execute.sv */
`timescale 1ns/1ps

module warp_execute (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  logic [warp_pkg::ILEN-1:0]       i_inst,
    output logic                            o_ready,
    output logic [warp_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [warp_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    input  logic [warp_pkg::XLEN-1:0]       i_rs1_rdata,
    input  logic [warp_pkg::XLEN-1:0]       i_rs2_rdata,
    output logic                            o_rd_wen,
    output logic [warp_pkg::REG_ADDR_W-1:0] o_rd_addr,
    output logic [warp_pkg::XLEN-1:0]       o_rd_wdata,
    output logic                            o_wb_valid,
    output logic [warp_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [warp_pkg::XLEN-1:0]       o_wb_data,
    input  logic                            i_wb_ready
);
    warp_pkg::inst_u                 inst;
    logic                            fire;
    logic                            is_imm;
    logic                            is_word;
    logic                            is_sub;
    logic [warp_pkg::XLEN-1:0]       imm_ext;
    logic [warp_pkg::XLEN-1:0]       op_a;
    logic [warp_pkg::XLEN-1:0]       op_b;
    logic [warp_pkg::XLEN-1:0]       sum;
    logic [warp_pkg::XLEN-1:0]       result;
    logic                            wb_valid;
    logic [warp_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [warp_pkg::XLEN-1:0]       wb_data;

    assign inst = i_inst;

    // a held write-back that is not yet taken blocks the next instruction
    assign o_ready = !wb_valid || i_wb_ready;
    assign fire    = i_valid && o_ready;

    assign is_imm  = (inst.i.opcode == warp_pkg::OP_IMM) ||
                     (inst.i.opcode == warp_pkg::OP_IMM_W);
    assign is_word = (inst.r.opcode == warp_pkg::OP_REG_W) ||
                     (inst.r.opcode == warp_pkg::OP_IMM_W);
    // funct7 is immediate bits in the I-type view, so only register forms subtract
    assign is_sub  = !is_imm && (inst.r.funct7 == warp_pkg::F7_SUB);
    assign imm_ext = {{(warp_pkg::XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    assign o_rs1_addr = inst.r.rs1;
    assign o_rs2_addr = inst.r.rs2;

    assign op_a = i_rs1_rdata;
    assign op_b = is_imm ? imm_ext : i_rs2_rdata;
    assign sum  = is_sub ? (op_a - op_b) : (op_a + op_b);

    always_comb begin
        case (inst.r.funct3)
            warp_pkg::F3_ADD_SUB: begin
                if (is_word) begin
                    result = {{(warp_pkg::XLEN-32){sum[31]}}, sum[31:0]};
                end else begin
                    result = sum;
                end
            end
            warp_pkg::F3_SLT: begin
                result = {{(warp_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            warp_pkg::F3_SLTU: begin
                result = {{(warp_pkg::XLEN-1){1'b0}}, op_a < op_b};
            end
            warp_pkg::F3_XOR: begin
                result = op_a ^ op_b;
            end
            warp_pkg::F3_OR: begin
                result = op_a | op_b;
            end
            warp_pkg::F3_AND: begin
                result = op_a & op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // the register file takes the result on the same edge that raises o_wb_valid
    assign o_rd_wen   = fire;
    assign o_rd_addr  = inst.r.rd;
    assign o_rd_wdata = result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wb_valid <= 1'b0;
        end else if (fire) begin
            wb_valid <= 1'b1;
        end else if (i_wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fire) begin
            wb_rd   <= inst.r.rd;
            wb_data <= result;
        end
    end

    assign o_wb_valid = wb_valid;
    assign o_wb_rd    = wb_rd;
    assign o_wb_data  = wb_data;
endmodule

/* rtl/warp_issue_queue.sv */
`timescale 1ns/1ps

module warp_issue_queue #(
    parameter int DEPTH = warp_pkg::QUEUE_DEPTH
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_in_valid,
    input  logic [warp_pkg::ILEN-1:0] i_in_inst,
    output logic                      o_in_ready,
    output logic                      o_out_valid,
    output logic [warp_pkg::ILEN-1:0] o_out_inst,
    input  logic                      i_out_ready
);
    logic [warp_pkg::ILEN-1:0]    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         full;
    logic                         empty;
    logic                         push;
    logic                         pop;

    assign full  = (32'(count) == DEPTH);
    assign empty = (count == '0);
    assign push  = i_in_valid && !full;
    assign pop   = !empty && i_out_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_in_inst;
        end
    end

    // pointers wrap explicitly so that DEPTH need not be a power of two
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a word written this cycle shows at the output no earlier than the next
    assign o_in_ready  = !full;
    assign o_out_valid = !empty;
    assign o_out_inst  = mem[rd_ptr];
endmodule

/* rtl/warp_pkg.sv */
package warp_pkg;

    // datapath and instruction widths
    localparam int XLEN        = 64;
    localparam int ILEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int QUEUE_DEPTH = 4;

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG_W = 7'b0111011;
    localparam logic [6:0] OP_IMM_W = 7'b0011011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_s;

    // the upper seven bits of imm overlay funct7 of the R-type view
    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_s;

    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
    } inst_u;

endpackage

/* rtl/warp_xrf.sv */
`timescale 1ns/1ps

module warp_xrf (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [warp_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [warp_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    output logic [warp_pkg::XLEN-1:0]       o_rs1_rdata,
    output logic [warp_pkg::XLEN-1:0]       o_rs2_rdata,
    input  logic                            i_rd_wen,
    input  logic [warp_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [warp_pkg::XLEN-1:0]       i_rd_wdata
);
    // x0 has no storage behind it
    logic [warp_pkg::XLEN-1:0] regs [1:warp_pkg::NUM_REGS-1];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < warp_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    // reads are combinational, a write shows up after the clock edge
    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_rdata = '0;
        end else begin
            o_rs1_rdata = regs[i_rs1_addr];
        end
    end

    always_comb begin
        if (i_rs2_addr == '0) begin
            o_rs2_rdata = '0;
        end else begin
            o_rs2_rdata = regs[i_rs2_addr];
        end
    end
endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            o_clk = ~o_clk;
        end
    end
endmodule

/* verification/tb_warp_core.sv */
`timescale 1ns/1ps

module tb_warp_core;
    logic        clk;
    logic        i_rst_n;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic        o_inst_ready;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [63:0] o_wb_data;
    logic        i_wb_ready;
    logic        ready_next;
    logic [31:0] lfsr_state = 32'h680e;

    // program table and the write-backs still owed by the DUT
    logic [31:0] prog_inst [$];
    bit          prog_wb   [$];
    logic [4:0]  prog_rd   [$];
    logic [63:0] prog_data [$];
    logic [4:0]  exp_rd    [$];
    logic [63:0] exp_data  [$];
    logic [4:0]  want_rd;
    logic [63:0] want_data;
    int          value_errors   = 0;
    int          other_errors   = 0;
    int          retired        = 0;
    int          expected_total = 0;
    int          limit;

    tb_clock #(.PERIOD_NS(10.0)) clock (.o_clk(clk));

    warp_core uut (
        .i_clk(clk), .i_rst_n(i_rst_n),
        .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .i_wb_ready(i_wb_ready)
    );

    bind warp_core warp_core_properties properties (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wb_valid(o_wb_valid), .i_wb_rd(o_wb_rd), .i_wb_data(o_wb_data),
        .i_wb_ready(i_wb_ready),
        .i_push_valid(dec_valid), .i_push_ready(dec_ready),
        .i_pop_valid(iq_valid), .i_pop_ready(iq_ready)
    );

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic bit next_random_bit();
        bit fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] reg_word(input bit word, input logic [2:0] f3,
                                             input bit sub, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] op;
        logic [6:0] f7;
        op = word ? warp_pkg::OP_REG_W : warp_pkg::OP_REG;
        f7 = sub ? warp_pkg::F7_SUB : warp_pkg::F7_BASE;
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] imm_word(input bit word, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        logic [6:0] op;
        op = word ? warp_pkg::OP_IMM_W : warp_pkg::OP_IMM;
        return {imm, rs1, f3, rd, op};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic [63:0] data);
        prog_inst.push_back(word);
        prog_wb.push_back(1'b1);
        prog_rd.push_back(word[11:7]);
        prog_data.push_back(data);
    endtask

    task automatic skip_entry(input logic [31:0] word);
        prog_inst.push_back(word);
        prog_wb.push_back(1'b0);
        prog_rd.push_back(5'd0);
        prog_data.push_back(64'd0);
    endtask

    task automatic build_program();
        add_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 1, 0, 12'h005), 64'd5);
        add_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 2, 0, 12'hffd), -64'd3);
        add_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 3, 1, 12'h064), 64'd105);
        skip_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 0, 1, 12'h007));
        add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 0, 5, 1, 2), 64'd2);
        add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 0, 14, 5, 5), 64'd4);
        add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 1, 6, 1, 2), 64'd8);
        add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 1, 7, 2, 1), -64'd8);
        // a shift immediate is not in the kept subset
        skip_entry(imm_word(0, 3'b001, 9, 1, 12'h001));
        add_entry(reg_word(0, warp_pkg::F3_SLT, 0, 8, 2, 1), 64'd1);
        add_entry(reg_word(0, warp_pkg::F3_SLT, 0, 30, 1, 2), 64'd0);
        add_entry(reg_word(0, warp_pkg::F3_SLTU, 0, 9, 2, 1), 64'd0);
        add_entry(reg_word(0, warp_pkg::F3_SLTU, 0, 10, 1, 2), 64'd1);
        add_entry(reg_word(0, warp_pkg::F3_AND, 0, 11, 7, 3), 64'd104);
        add_entry(reg_word(0, warp_pkg::F3_OR, 0, 12, 1, 7), -64'd3);
        add_entry(reg_word(0, warp_pkg::F3_XOR, 0, 13, 6, 7), -64'd16);
        skip_entry(reg_word(0, warp_pkg::F3_XOR, 1, 13, 6, 7));
        skip_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 0, 0, 1, 1));
        add_entry(imm_word(0, warp_pkg::F3_SLT, 15, 2, 12'hffe), 64'd1);
        add_entry(imm_word(0, warp_pkg::F3_SLTU, 16, 1, 12'hfff), 64'd1);
        add_entry(imm_word(0, warp_pkg::F3_SLTU, 17, 2, 12'h004), 64'd0);
        add_entry(imm_word(0, warp_pkg::F3_AND, 18, 2, 12'h0f0), 64'h0f0);
        add_entry(imm_word(0, warp_pkg::F3_OR, 19, 1, 12'hff0), -64'd11);
        add_entry(imm_word(0, warp_pkg::F3_XOR, 20, 1, 12'hfff), -64'd6);
        add_entry(imm_word(0, warp_pkg::F3_AND, 21, 7, 12'h800), -64'd2048);
        skip_entry(32'h0000_0073);
        // x22 doubles up to 0x7ff00000 so that word forms can overflow
        add_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 22, 0, 12'h7ff), 64'h7ff);
        for (int k = 1; k <= 20; k++) begin
            add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 0, 22, 22, 22), 64'h7ff << k);
        end
        add_entry(reg_word(0, warp_pkg::F3_ADD_SUB, 0, 25, 22, 22), 64'h0000_0000_ffe0_0000);
        add_entry(reg_word(1, warp_pkg::F3_ADD_SUB, 0, 23, 22, 22), 64'hffff_ffff_ffe0_0000);
        add_entry(imm_word(1, warp_pkg::F3_ADD_SUB, 24, 25, 12'hfff), 64'hffff_ffff_ffdf_ffff);
        add_entry(imm_word(1, warp_pkg::F3_ADD_SUB, 26, 2, 12'h00a), 64'd7);
        add_entry(reg_word(1, warp_pkg::F3_ADD_SUB, 1, 28, 0, 25), 64'h0000_0000_0020_0000);
        add_entry(reg_word(1, warp_pkg::F3_ADD_SUB, 1, 29, 0, 22), 64'hffff_ffff_8010_0000);
        skip_entry(reg_word(1, warp_pkg::F3_SLT, 0, 27, 1, 1));
        skip_entry(32'h0000_0000);
        add_entry(imm_word(0, warp_pkg::F3_ADD_SUB, 31, 29, 12'h001), 64'hffff_ffff_8010_0001);
        add_entry(reg_word(0, warp_pkg::F3_XOR, 0, 27, 23, 24), 64'h0000_0000_003f_ffff);
    endtask

    // an optional idle gap of one to four cycles, then hold the word until taken
    task automatic send_word(input logic [31:0] word);
        bit accepted;
        int gap;
        gap = 0;
        if (next_random_bit()) begin
            gap = 1;
            if (next_random_bit()) gap += 2;
            if (next_random_bit()) gap += 1;
        end
        i_inst_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        i_inst_valid = 1'b1;
        i_inst       = word;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = o_inst_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d of %0d write-backs retired, %0d value errors, %0d other errors",
                 retired, expected_total, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        build_program();
        foreach (prog_inst[n]) begin
            if (prog_wb[n]) begin
                exp_rd.push_back(prog_rd[n]);
                exp_data.push_back(prog_data[n]);
            end
        end
        expected_total = exp_rd.size();
        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        foreach (prog_inst[n]) begin
            send_word(prog_inst[n]);
        end
        i_inst_valid = 1'b0;
        wait (retired == expected_total);
        // a few more cycles to catch any extra write-back
        repeat (20) @(posedge clk);
        finish_run();
    end

    // the consumer stalls on about half of the cycles
    initial begin
        i_wb_ready = 1'b0;
        forever begin
            @(negedge clk);
            ready_next = next_random_bit();
            @(posedge clk);
            #1;
            i_wb_ready = ready_next;
        end
    end

    // a transfer happens at the next rising edge, so outputs are sampled at the falling one
    always @(negedge clk) begin
        if (i_rst_n && o_wb_valid && i_wb_ready) begin
            assert (exp_rd.size() != 0) else begin
                $display("a write-back appeared with no instruction left to retire");
                other_errors++;
            end
            if (exp_rd.size() != 0) begin
                want_rd   = exp_rd.pop_front();
                want_data = exp_data.pop_front();
                assert (o_wb_rd == want_rd) else begin
                    $display("error o_wb_rd got %h expected %h", o_wb_rd, want_rd);
                    value_errors++;
                end
                assert (o_wb_data == want_data) else begin
                    $display("error o_wb_data got %h expected %h", o_wb_data, want_data);
                    value_errors++;
                end
                retired++;
            end
        end
    end

    initial begin
        wait (expected_total > 0);
        limit = 16 + 40 * prog_inst.size();
        repeat (limit) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles", limit);
        other_errors++;
        finish_run();
    end
endmodule

/* verification/warp_core_properties.sv */
`timescale 1ns/1ps

module warp_core_properties (
    input logic                            i_clk,
    input logic                            i_rst_n,
    input logic                            i_wb_valid,
    input logic [warp_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input logic [warp_pkg::XLEN-1:0]       i_wb_data,
    input logic                            i_wb_ready,
    input logic                            i_push_valid,
    input logic                            i_push_ready,
    input logic                            i_pop_valid,
    input logic                            i_pop_ready
);
    logic [$clog2(warp_pkg::QUEUE_DEPTH+1)-1:0] occupancy;
    logic                                       push;
    logic                                       pop;

    assign push = i_push_valid && i_push_ready;
    assign pop  = i_pop_valid && i_pop_ready;

    // shadow count of the issue queue, built from its two handshakes
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + push - pop;
        end
    end

    wb_idle_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_wb_valid)
        else $error("write-back valid raised right after a reset cycle");

    wb_held_while_stalled: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_valid && !i_wb_ready) |=>
        (i_wb_valid && $stable(i_wb_rd) && $stable(i_wb_data)))
        else $error("write-back changed while the consumer stalled it");

    no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        push |-> (32'(occupancy) < warp_pkg::QUEUE_DEPTH))
        else $error("issue queue took a word while full");

    no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pop |-> (occupancy != '0))
        else $error("issue queue gave a word while empty");
endmodule
